// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= udp_reply_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+hdl
hdl/udp_reply_pkg.sv
hdl/spi_bit_timer.sv
hdl/spi_flash_reader.sv
hdl/net_config_loader.sv
hdl/udp_port_steer.sv
hdl/reply_pattern_source.sv
hdl/payload_fifo.sv
hdl/udp_reply_top.sv
verif/udp_reply_tb.sv

// File: hdl/net_config_loader.sv
`timescale 1ns/1ps
`include "udp_reply_params.svh"

module net_config_loader (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_reply_pkg::byte_t    flash_tdata,
    input  logic                    flash_tvalid,
    output logic                    flash_tready,
    output udp_reply_pkg::ip_addr_t local_ip,
    output udp_reply_pkg::ip_addr_t gateway_ip,
    output udp_reply_pkg::ip_addr_t subnet_mask,
    output logic                    config_done
);
    logic [4:0] byte_cnt;
    logic [4:0] rel;
    logic [2:0] nib_idx;
    logic       accept;

    assign flash_tready = !config_done;
    assign accept       = flash_tvalid && flash_tready;
    assign rel          = byte_cnt - 5'(`CONFIG_SKIP_BYTES);
    // Pair number picks the octet from the top, odd byte is the high nibble
    assign nib_idx      = {~rel[2:1], rel[0]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            byte_cnt    <= 5'd0;
            config_done <= 1'b0;
            local_ip    <= '0;
            gateway_ip  <= '0;
            subnet_mask <= '0;
        end
        else if (accept)
        begin
            byte_cnt <= byte_cnt + 5'd1;
            if (byte_cnt == 5'(`CONFIG_BYTES - 1))
                config_done <= 1'b1;
            if (byte_cnt >= 5'(`CONFIG_SKIP_BYTES))
            begin
                case (rel[4:3])
                    2'd0: local_ip[4*nib_idx +: 4] <= flash_tdata[3:0];
                    2'd1: gateway_ip[4*nib_idx +: 4] <= flash_tdata[3:0];
                    2'd2: subnet_mask[4*nib_idx +: 4] <= flash_tdata[3:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: hdl/payload_fifo.sv
`timescale 1ns/1ps
`include "udp_reply_params.svh"

module payload_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  udp_reply_pkg::byte_t push_data,
    input  logic                 push_last,
    input  logic                 push_user,
    output logic                 full,
    output udp_reply_pkg::byte_t tdata,
    output logic                 tvalid,
    output logic                 tlast,
    output logic                 tuser,
    input  logic                 tready
);
    localparam int AW    = `FIFO_ADDR_BITS;
    localparam int DEPTH = 1 << AW;
    localparam int CNT_W = AW + 1;

    // Entry is {user, last, data}
    logic [9:0]       mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr;
    logic             rd;

    assign full   = (count == CNT_W'(DEPTH));
    assign tvalid = (count != '0);
    assign wr     = push && !full;
    assign rd     = tvalid && tready;

    assign {tuser, tlast, tdata} = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_ptr] <= {push_user, push_last, push_data};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr)
                wr_ptr <= wr_ptr + AW'(1);
            if (rd)
                rd_ptr <= rd_ptr + AW'(1);
            if (wr && !rd)
                count <= count + CNT_W'(1);
            else if (rd && !wr)
                count <= count - CNT_W'(1);
        end
    end

endmodule

// File: hdl/reply_pattern_source.sv
`timescale 1ns/1ps
`include "udp_reply_params.svh"

module reply_pattern_source (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  udp_reply_pkg::ip_addr_t local_ip,
    input  udp_reply_pkg::ip_addr_t gateway_ip,
    input  udp_reply_pkg::ip_addr_t subnet_mask,
    output udp_reply_pkg::byte_t    pattern_byte
);
    import udp_reply_pkg::*;

    pattern_idx_t ptr;
    logic [4:0]   octet_lsb;

    // Entry 0 of each word is its top octet
    assign octet_lsb = {~ptr[1:0], 3'b000};

    always_ff @(posedge clk)
    begin
        if (rst)
            ptr <= '0;
        else if (advance)
            ptr <= ptr + pattern_idx_t'(1);
    end

    always_comb
    begin
        case (ptr[3:2])
            2'd0: pattern_byte = local_ip[octet_lsb +: 8];
            2'd1: pattern_byte = gateway_ip[octet_lsb +: 8];
            2'd2: pattern_byte = subnet_mask[octet_lsb +: 8];
            default:
            begin
                case (ptr[1:0])
                    2'd0: pattern_byte = `PATTERN_TAIL0;
                    2'd1: pattern_byte = `PATTERN_TAIL1;
                    2'd2: pattern_byte = `PATTERN_TAIL2;
                    default: pattern_byte = `PATTERN_TAIL3;
                endcase
            end
        endcase
    end

endmodule

// File: hdl/spi_bit_timer.sv
`timescale 1ns/1ps
`include "udp_reply_params.svh"

module spi_bit_timer (
    input  logic clk,
    input  logic rst,
    input  logic bit_enable,
    output logic sck_rise,
    output logic sck_fall,
    output logic byte_done
);
    localparam int HALF = `SPI_HALF_PERIOD;
    localparam int DIV_W = $clog2(HALF + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             sck_phase;
    logic [2:0]       bit_cnt;
    logic             tick;

    assign tick      = bit_enable && (div_cnt == DIV_W'(HALF - 1));
    // Phase low means the next edge is a rising one
    assign sck_rise  = tick && !sck_phase;
    assign sck_fall  = tick && sck_phase;
    assign byte_done = sck_rise && (bit_cnt == 3'd7);

    always_ff @(posedge clk)
    begin
        if (rst || !bit_enable)
        begin
            div_cnt   <= '0;
            sck_phase <= 1'b0;
            bit_cnt   <= 3'd0;
        end
        else if (tick)
        begin
            div_cnt   <= '0;
            sck_phase <= ~sck_phase;
            if (sck_rise)
                bit_cnt <= bit_cnt + 3'd1;
        end
        else
        begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

endmodule

// File: hdl/spi_flash_reader.sv
`timescale 1ns/1ps
`include "udp_reply_params.svh"

module spi_flash_reader (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 spi_sck,
    output logic                 spi_mosi,
    output logic                 spi_cs,
    input  logic                 spi_miso,
    output udp_reply_pkg::byte_t flash_tdata,
    output logic                 flash_tvalid,
    input  logic                 flash_tready
);
    import udp_reply_pkg::*;

    flash_state_t state;
    logic [31:0]  cmd_sr;
    logic [1:0]   cmd_cnt;
    byte_t        rx_sr;
    logic         bit_enable;
    logic         sck_rise;
    logic         sck_fall;
    logic         byte_done;

    assign bit_enable = (state == st_command) || (state == st_data);
    assign spi_mosi   = cmd_sr[31];

    spi_bit_timer bit_timer0 (
        .clk        (clk),
        .rst        (rst),
        .bit_enable (bit_enable),
        .sck_rise   (sck_rise),
        .sck_fall   (sck_fall),
        .byte_done  (byte_done)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= st_idle;
            spi_cs       <= 1'b1;
            spi_sck      <= 1'b0;
            cmd_sr       <= '0;
            cmd_cnt      <= 2'd0;
            flash_tvalid <= 1'b0;
        end
        else
        begin
            if (flash_tvalid && flash_tready)
                flash_tvalid <= 1'b0;

            if (sck_rise)
                spi_sck <= 1'b1;
            else if (sck_fall)
                spi_sck <= 1'b0;

            // Mode 0, next MOSI bit goes out after each falling edge
            if (sck_fall)
                cmd_sr <= {cmd_sr[30:0], 1'b0};

            case (state)
                st_idle:
                begin
                    spi_cs <= 1'b0;
                    cmd_sr <= {`FLASH_READ_CMD, `FLASH_CONFIG_ADDR};
                    state  <= st_command;
                end
                st_command:
                begin
                    if (byte_done)
                    begin
                        cmd_cnt <= cmd_cnt + 2'd1;
                        if (cmd_cnt == 2'd3)
                            state <= st_data;
                    end
                end
                st_data:
                begin
                    if (byte_done)
                    begin
                        if (flash_tready)
                        begin
                            flash_tvalid <= 1'b1;
                        end
                        else
                        begin
                            // Loader is full, deselect the flash
                            state   <= st_done;
                            spi_cs  <= 1'b1;
                            spi_sck <= 1'b0;
                        end
                    end
                end
                st_done:
                begin
                    state <= st_done;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // MISO sampled on rising edges
    always_ff @(posedge clk)
    begin
        if (sck_rise)
            rx_sr <= {rx_sr[6:0], spi_miso};
        if (byte_done && (state == st_data))
            flash_tdata <= {rx_sr[6:0], spi_miso};
    end

endmodule

// File: hdl/udp_port_steer.sv
`timescale 1ns/1ps
`include "udp_reply_params.svh"

module udp_port_steer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_udp_hdr_valid,
    output logic                     rx_udp_hdr_ready,
    input  udp_reply_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_reply_pkg::udp_port_t rx_udp_source_port,
    input  udp_reply_pkg::udp_port_t rx_udp_dest_port,
    input  udp_reply_pkg::udp_len_t  rx_udp_length,
    input  udp_reply_pkg::ip_addr_t  local_ip,
    output logic                     tx_udp_hdr_valid,
    input  logic                     tx_udp_hdr_ready,
    output udp_reply_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_reply_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_reply_pkg::udp_port_t tx_udp_source_port,
    output udp_reply_pkg::udp_port_t tx_udp_dest_port,
    output udp_reply_pkg::udp_len_t  tx_udp_length,
    input  logic                     rx_udp_payload_tvalid,
    output logic                     rx_udp_payload_tready,
    input  logic                     rx_udp_payload_tlast,
    input  logic                     rx_udp_payload_tuser,
    output logic                     push,
    output logic                     push_last,
    output logic                     push_user,
    input  logic                     fifo_full
);
    import udp_reply_pkg::*;

    logic port_match;
    logic verdict_valid;
    logic verdict_match;

    assign port_match = (rx_udp_dest_port == udp_port_t'(`REPLY_PORT));

    assign tx_udp_hdr_valid = rx_udp_hdr_valid && port_match;
    assign rx_udp_hdr_ready = port_match ? tx_udp_hdr_ready : 1'b1;

    // Reply goes back to the sender with the ports swapped
    assign tx_ip_source_ip    = local_ip;
    assign tx_ip_dest_ip      = rx_ip_source_ip;
    assign tx_udp_source_port = rx_udp_dest_port;
    assign tx_udp_dest_port   = rx_udp_source_port;
    assign tx_udp_length      = rx_udp_length;

    assign rx_udp_payload_tready = verdict_valid && (verdict_match ? !fifo_full : 1'b1);
    assign push      = verdict_valid && verdict_match && rx_udp_payload_tvalid && !fifo_full;
    assign push_last = rx_udp_payload_tlast;
    assign push_user = rx_udp_payload_tuser;

    // Verdict taken on the first beat, held to tlast
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            verdict_valid <= 1'b0;
            verdict_match <= 1'b0;
        end
        else if (!verdict_valid && rx_udp_payload_tvalid)
        begin
            verdict_valid <= 1'b1;
            verdict_match <= port_match;
        end
        else if (rx_udp_payload_tvalid && rx_udp_payload_tready && rx_udp_payload_tlast)
        begin
            verdict_valid <= 1'b0;
        end
    end

endmodule

// File: hdl/udp_reply_params.svh
`ifndef UDP_REPLY_PARAMS_SVH
`define UDP_REPLY_PARAMS_SVH

// Flash layout of the network configuration block
`define FLASH_READ_CMD      8'h03
`define FLASH_CONFIG_ADDR   24'h000000
`define CONFIG_SKIP_BYTES   2
`define CONFIG_BYTES        26

// clk cycles per half SCK period
`define SPI_HALF_PERIOD     4

`define REPLY_PORT          16'd1234
`define FIFO_ADDR_BITS      4

// Fixed tail of the reply pattern
`define PATTERN_TAIL0       8'h11
`define PATTERN_TAIL1       8'h22
`define PATTERN_TAIL2       8'h33
`define PATTERN_TAIL3       8'h44

`endif

// File: hdl/udp_reply_pkg.sv
package udp_reply_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [3:0]  pattern_idx_t;

    // Flash reader sequence
    typedef enum logic [1:0] {
        st_idle,
        st_command,
        st_data,
        st_done
    } flash_state_t;

endpackage

// File: hdl/udp_reply_top.sv
`timescale 1ns/1ps

module udp_reply_top (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     spi_sck,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    output logic                     spi_cs,
    output logic                     config_done,
    input  logic                     rx_udp_hdr_valid,
    output logic                     rx_udp_hdr_ready,
    input  udp_reply_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_reply_pkg::udp_port_t rx_udp_source_port,
    input  udp_reply_pkg::udp_port_t rx_udp_dest_port,
    input  udp_reply_pkg::udp_len_t  rx_udp_length,
    input  logic                     rx_udp_payload_tvalid,
    output logic                     rx_udp_payload_tready,
    input  logic                     rx_udp_payload_tlast,
    input  logic                     rx_udp_payload_tuser,
    output logic                     tx_udp_hdr_valid,
    input  logic                     tx_udp_hdr_ready,
    output udp_reply_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_reply_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_reply_pkg::udp_port_t tx_udp_source_port,
    output udp_reply_pkg::udp_port_t tx_udp_dest_port,
    output udp_reply_pkg::udp_len_t  tx_udp_length,
    output udp_reply_pkg::byte_t     tx_udp_payload_tdata,
    output logic                     tx_udp_payload_tvalid,
    input  logic                     tx_udp_payload_tready,
    output logic                     tx_udp_payload_tlast,
    output logic                     tx_udp_payload_tuser
);
    import udp_reply_pkg::*;

    byte_t    flash_tdata;
    logic     flash_tvalid;
    logic     flash_tready;
    ip_addr_t local_ip;
    ip_addr_t gateway_ip;
    ip_addr_t subnet_mask;
    byte_t    pattern_byte;
    logic     push;
    logic     push_last;
    logic     push_user;
    logic     fifo_full;

    spi_flash_reader flash_reader0 (
        .clk          (clk),
        .rst          (rst),
        .spi_sck      (spi_sck),
        .spi_mosi     (spi_mosi),
        .spi_cs       (spi_cs),
        .spi_miso     (spi_miso),
        .flash_tdata  (flash_tdata),
        .flash_tvalid (flash_tvalid),
        .flash_tready (flash_tready)
    );

    net_config_loader config_loader0 (
        .clk          (clk),
        .rst          (rst),
        .flash_tdata  (flash_tdata),
        .flash_tvalid (flash_tvalid),
        .flash_tready (flash_tready),
        .local_ip     (local_ip),
        .gateway_ip   (gateway_ip),
        .subnet_mask  (subnet_mask),
        .config_done  (config_done)
    );

    // One pattern step per pushed byte
    reply_pattern_source pattern0 (
        .clk          (clk),
        .rst          (rst),
        .advance      (push),
        .local_ip     (local_ip),
        .gateway_ip   (gateway_ip),
        .subnet_mask  (subnet_mask),
        .pattern_byte (pattern_byte)
    );

    udp_port_steer steer0 (
        .clk                   (clk),
        .rst                   (rst),
        .rx_udp_hdr_valid      (rx_udp_hdr_valid),
        .rx_udp_hdr_ready      (rx_udp_hdr_ready),
        .rx_ip_source_ip       (rx_ip_source_ip),
        .rx_udp_source_port    (rx_udp_source_port),
        .rx_udp_dest_port      (rx_udp_dest_port),
        .rx_udp_length         (rx_udp_length),
        .local_ip              (local_ip),
        .tx_udp_hdr_valid      (tx_udp_hdr_valid),
        .tx_udp_hdr_ready      (tx_udp_hdr_ready),
        .tx_ip_source_ip       (tx_ip_source_ip),
        .tx_ip_dest_ip         (tx_ip_dest_ip),
        .tx_udp_source_port    (tx_udp_source_port),
        .tx_udp_dest_port      (tx_udp_dest_port),
        .tx_udp_length         (tx_udp_length),
        .rx_udp_payload_tvalid (rx_udp_payload_tvalid),
        .rx_udp_payload_tready (rx_udp_payload_tready),
        .rx_udp_payload_tlast  (rx_udp_payload_tlast),
        .rx_udp_payload_tuser  (rx_udp_payload_tuser),
        .push                  (push),
        .push_last             (push_last),
        .push_user             (push_user),
        .fifo_full             (fifo_full)
    );

    payload_fifo fifo0 (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (pattern_byte),
        .push_last (push_last),
        .push_user (push_user),
        .full      (fifo_full),
        .tdata     (tx_udp_payload_tdata),
        .tvalid    (tx_udp_payload_tvalid),
        .tlast     (tx_udp_payload_tlast),
        .tuser     (tx_udp_payload_tuser),
        .tready    (tx_udp_payload_tready)
    );

endmodule

// File: verif/udp_reply_tb.sv
`timescale 1ns/1ps
`include "udp_reply_params.svh"

module udp_reply_tb;
    import udp_reply_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int IMAGE_BYTES  = 32;
    localparam int SKIPPED_BYTES = 2;
    localparam int NUM_FRAMES   = 48;
    localparam int NUM_LONG     = 6;
    localparam int MAX_LEN      = 40;
    localparam int STALL_FACTOR = 10;
    // Command, config bytes and the one extra byte read before CS rises
    localparam int FLASH_CYCLES = (4 + `CONFIG_BYTES + 1) * 16 * `SPI_HALF_PERIOD;
    localparam int RUN_CYCLES   = 2 * FLASH_CYCLES
                                + (NUM_FRAMES + NUM_LONG + 2) * (MAX_LEN + 8) * STALL_FACTOR;

    logic      clk = 1'b0;
    logic      rst;
    logic      spi_sck;
    logic      spi_mosi;
    logic      spi_miso = 1'b0;
    logic      spi_cs;
    logic      config_done;
    logic      rx_udp_hdr_valid;
    logic      rx_udp_hdr_ready;
    ip_addr_t  rx_ip_source_ip;
    udp_port_t rx_udp_source_port;
    udp_port_t rx_udp_dest_port;
    udp_len_t  rx_udp_length;
    logic      rx_udp_payload_tvalid;
    logic      rx_udp_payload_tready;
    logic      rx_udp_payload_tlast;
    logic      rx_udp_payload_tuser;
    logic      tx_udp_hdr_valid;
    logic      tx_udp_hdr_ready = 1'b0;
    ip_addr_t  tx_ip_source_ip;
    ip_addr_t  tx_ip_dest_ip;
    udp_port_t tx_udp_source_port;
    udp_port_t tx_udp_dest_port;
    udp_len_t  tx_udp_length;
    byte_t     tx_udp_payload_tdata;
    logic      tx_udp_payload_tvalid;
    logic      tx_udp_payload_tready = 1'b0;
    logic      tx_udp_payload_tlast;
    logic      tx_udp_payload_tuser;

    byte_t        flash_image [IMAGE_BYTES];
    logic [31:0]  flash_cmd = '0;
    int           sck_rises = 0;
    logic [31:0]  rng_stim = 32'd63532;
    logic [31:0]  rng_ready = 32'd63532 + 32'd1;
    logic         heavy_stall = 1'b0;
    logic         frame_match = 1'b0;
    pattern_idx_t model_ptr = '0;
    ip_addr_t     exp_local_ip = '0;
    int           in_flight = 0;
    int           max_fill = 0;
    // {src ip, dst ip, src port, dst port, length}
    logic [111:0] hdr_q [$];
    // {user, last, data}
    logic [9:0]   beat_q [$];

    udp_reply_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_stim = xorshift32(rng_stim);
        return rng_stim;
    endfunction

    function automatic logic flash_bit(input int idx);
        byte_t b;
        if (idx >= IMAGE_BYTES * 8)
            return 1'b0;
        b = flash_image[idx / 8];
        return b[7 - (idx % 8)];
    endfunction

    // Expected reply byte for a pattern entry from the flash image
    function automatic byte_t expected_pattern(input pattern_idx_t idx);
        int base;
        case (idx)
            4'd12: return 8'h11;
            4'd13: return 8'h22;
            4'd14: return 8'h33;
            4'd15: return 8'h44;
            default:
            begin
                base = SKIPPED_BYTES + 2 * int'(idx);
                return {flash_image[base + 1][3:0], flash_image[base][3:0]};
            end
        endcase
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string reason);
        $display("ERROR: %s", reason);
        abort_run();
    endtask

    task automatic check_ip(input string name, input ip_addr_t got, input ip_addr_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_port(input string name, input udp_port_t got, input udp_port_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_len(input string name, input udp_len_t got, input udp_len_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    // Mode 0 flash model with command bits in on rising SCK
    always @(posedge spi_sck)
    begin
        if (!spi_cs)
        begin
            if (sck_rises < 32)
                flash_cmd = {flash_cmd[30:0], spi_mosi};
            sck_rises = sck_rises + 1;
        end
    end

    always @(negedge spi_sck)
    begin
        if (!spi_cs && sck_rises >= 32)
            spi_miso = flash_bit(sck_rises - 32);
    end

    // Random back-pressure on both transmit readies
    always @(negedge clk)
    begin
        rng_ready = xorshift32(rng_ready);
        tx_udp_hdr_ready = rng_ready[4];
        if (heavy_stall)
            tx_udp_payload_tready = (rng_ready[2:0] == 3'd0);
        else
            tx_udp_payload_tready = (rng_ready[1:0] != 2'd0);
    end

    always @(posedge clk)
    begin
        logic [111:0] exp_hdr;
        logic [9:0]   exp_beat;
        if (!rst)
        begin
            check_flag("tx_udp_hdr_valid", tx_udp_hdr_valid,
                       rx_udp_hdr_valid && frame_match);
            check_flag("rx_udp_hdr_ready", rx_udp_hdr_ready,
                       frame_match ? tx_udp_hdr_ready : 1'b1);
            if (tx_udp_hdr_valid && hdr_q.size() == 0)
                stop_with_error("reply header raised for a frame that needs no reply");
            if (tx_udp_hdr_valid && tx_udp_hdr_ready)
            begin
                exp_hdr = hdr_q.pop_front();
                check_ip("tx_ip_source_ip", tx_ip_source_ip, exp_hdr[111:80]);
                check_ip("tx_ip_dest_ip", tx_ip_dest_ip, exp_hdr[79:48]);
                check_port("tx_udp_source_port", tx_udp_source_port, exp_hdr[47:32]);
                check_port("tx_udp_dest_port", tx_udp_dest_port, exp_hdr[31:16]);
                check_len("tx_udp_length", tx_udp_length, exp_hdr[15:0]);
            end
            if (tx_udp_payload_tvalid && tx_udp_payload_tready)
            begin
                if (beat_q.size() == 0)
                    stop_with_error("extra reply payload beat with nothing expected");
                exp_beat = beat_q.pop_front();
                check_byte("tx_udp_payload_tdata", tx_udp_payload_tdata, exp_beat[7:0]);
                check_flag("tx_udp_payload_tlast", tx_udp_payload_tlast, exp_beat[8]);
                check_flag("tx_udp_payload_tuser", tx_udp_payload_tuser, exp_beat[9]);
                in_flight = in_flight - 1;
            end
            if (rx_udp_payload_tvalid && rx_udp_payload_tready && frame_match)
                in_flight = in_flight + 1;
            if (in_flight > max_fill)
                max_fill = in_flight;
        end
    end

    task automatic send_frame(input udp_port_t dport, input int len);
        logic [31:0] r;
        ip_addr_t    src_ip;
        udp_port_t   sport;
        int          beat;
        r = next_random();
        src_ip = next_random();
        sport = r[15:0];
        @(negedge clk);
        frame_match = (dport == `REPLY_PORT);
        rx_ip_source_ip = src_ip;
        rx_udp_source_port = sport;
        rx_udp_dest_port = dport;
        rx_udp_length = udp_len_t'(len + 8);
        rx_udp_hdr_valid = 1'b1;
        if (frame_match)
            hdr_q.push_back({exp_local_ip, src_ip, dport, sport, udp_len_t'(len + 8)});
        do
            @(posedge clk);
        while (!rx_udp_hdr_ready);
        @(negedge clk);
        rx_udp_hdr_valid = 1'b0;
        // Header fields stay put for the verdict on the first beat
        for (beat = 0; beat < len; beat++)
        begin
            r = next_random();
            rx_udp_payload_tvalid = 1'b1;
            rx_udp_payload_tlast = (beat == len - 1);
            rx_udp_payload_tuser = (beat == len - 1) && (r[2:0] == 3'd0);
            if (frame_match)
            begin
                beat_q.push_back({rx_udp_payload_tuser, rx_udp_payload_tlast,
                                  expected_pattern(model_ptr)});
                model_ptr = model_ptr + 4'd1;
            end
            do
                @(posedge clk);
            while (!rx_udp_payload_tready);
            @(negedge clk);
        end
        rx_udp_payload_tvalid = 1'b0;
        rx_udp_payload_tlast = 1'b0;
        rx_udp_payload_tuser = 1'b0;
    endtask

    initial
    begin
        #(RUN_CYCLES * CLK_PERIOD);
        stop_with_error("watchdog timeout, the DUT stopped making progress");
    end

    initial
    begin
        logic [31:0] r;
        udp_port_t   port;
        int          i;
        rst = 1'b1;
        rx_udp_hdr_valid = 1'b0;
        rx_ip_source_ip = '0;
        rx_udp_source_port = '0;
        rx_udp_dest_port = '0;
        rx_udp_length = '0;
        rx_udp_payload_tvalid = 1'b0;
        rx_udp_payload_tlast = 1'b0;
        rx_udp_payload_tuser = 1'b0;
        for (i = 0; i < IMAGE_BYTES; i++)
        begin
            r = next_random();
            flash_image[i] = r[7:0];
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        check_flag("spi_cs", spi_cs, 1'b1);
        check_flag("spi_sck", spi_sck, 1'b0);
        check_flag("spi_mosi", spi_mosi, 1'b0);
        check_flag("config_done", config_done, 1'b0);
        check_flag("tx_udp_hdr_valid", tx_udp_hdr_valid, 1'b0);
        check_flag("tx_udp_payload_tvalid", tx_udp_payload_tvalid, 1'b0);
        rst = 1'b0;

        while (!config_done)
            @(posedge clk);
        @(negedge clk);
        check_byte("flash opcode", flash_cmd[31:24], 8'h03);
        check_ip("flash address", {8'h00, flash_cmd[23:0]}, 32'h00000000);
        if (sck_rises < 32 + 8 * `CONFIG_BYTES)
            stop_with_error("configuration done before all flash bytes were clocked");
        exp_local_ip = {expected_pattern(4'd0), expected_pattern(4'd1),
                        expected_pattern(4'd2), expected_pattern(4'd3)};

        // Pattern from entry 0 and then a dropped frame
        send_frame(`REPLY_PORT, 16);
        send_frame(16'd53, 12);
        for (i = 0; i < NUM_FRAMES; i++)
        begin
            r = next_random();
            port = (r[1:0] == 2'd0) ? `REPLY_PORT : r[31:16];
            if (r[1:0] != 2'd0 && port == `REPLY_PORT)
                port = port + 16'd1;
            send_frame(port, 1 + int'(next_random() % 32'(MAX_LEN)));
        end

        heavy_stall = 1'b1;
        for (i = 0; i < NUM_LONG; i++)
            send_frame(`REPLY_PORT, MAX_LEN);
        heavy_stall = 1'b0;

        while (hdr_q.size() != 0 || beat_q.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);
        if (!spi_cs)
            stop_with_error("flash still selected after the configuration read");
        if (max_fill < (1 << `FIFO_ADDR_BITS))
        begin
            stop_with_error("payload FIFO never filled during the stall phase");
        end
        else
        begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
